/* hdl/atomicPkg.sv */
////////////////////
// Atomic memory package
// Word width, address size, memory depth
// and the RISC-V request codes shared by the
// AMO datapath and the LR/SC tracker
////////////////////

`default_nettype none

package atomicPkg;

  ////////////////////
  // Sizes
  ////////////////////
  localparam int xlen     = 32;  // Data word width
  localparam int paBits   = 8;   // Byte address width
  localparam int memWords = 64;  // Word index is adr[7:2]

  ////////////////////
  // AMO operation codes
  ////////////////////
  // Taken from funct7[6:2]
  localparam logic [4:0] amoAdd  = 5'b00000;
  localparam logic [4:0] amoSwap = 5'b00001;
  localparam logic [4:0] amoXor  = 5'b00100;
  localparam logic [4:0] amoOr   = 5'b01000;
  localparam logic [4:0] amoAnd  = 5'b01100;
  localparam logic [4:0] amoMin  = 5'b10000;  // Signed
  localparam logic [4:0] amoMax  = 5'b10100;  // Signed
  localparam logic [4:0] amoMinu = 5'b11000;
  localparam logic [4:0] amoMaxu = 5'b11100;

  ////////////////////
  // Read/write codes
  ////////////////////
  localparam logic [1:0] rwNone  = 2'b00;
  localparam logic [1:0] rwWrite = 2'b01;
  localparam logic [1:0] rwRead  = 2'b10;
  localparam logic [1:0] rwAmo   = 2'b11;  // Read-modify-write

  // Atomic codes, bit 1 picks the AMO result as write data
  localparam logic [1:0] atomNone = 2'b00;
  localparam logic [1:0] atomLrsc = 2'b01;
  localparam logic [1:0] atomAmo  = 2'b10;

endpackage

`default_nettype wire

/* hdl/amoAlu.sv */
////////////////////
// AMO arithmetic unit
// Combinational new-word generator for RISC-V
// AMOs, covering swap, add, logic ops and the
// signed and unsigned min/max
////////////////////

`timescale 1ns/1ps
`default_nettype none

module amoAlu (
  input  logic [atomicPkg::xlen-1:0] srcA,   // Old memory word
  input  logic [atomicPkg::xlen-1:0] srcB,   // Register operand
  input  logic [6:0]                 funct,  // funct7, aq/rl bits ignored
  output logic [atomicPkg::xlen-1:0] result  // Word to store back
);

  logic [4:0]                 amoOp;      // funct7[6:2]
  logic [atomicPkg::xlen-1:0] sum;
  logic                       ltSigned;   // srcA < srcB, two's complement
  logic                       ltUnsigned; // srcA < srcB, magnitude
  logic [atomicPkg::xlen-1:0] minS;
  logic [atomicPkg::xlen-1:0] maxS;
  logic [atomicPkg::xlen-1:0] minU;
  logic [atomicPkg::xlen-1:0] maxU;

  assign amoOp = funct[6:2];

  ////////////////////
  // Shared arithmetic
  ////////////////////
  assign sum = srcA + srcB;  // Carry out dropped

  // One comparator each way
  assign ltSigned   = $signed(srcA) < $signed(srcB);
  assign ltUnsigned = srcA < srcB;

  assign minS = ltSigned   ? srcA : srcB;
  assign maxS = ltSigned   ? srcB : srcA;
  assign minU = ltUnsigned ? srcA : srcB;
  assign maxU = ltUnsigned ? srcB : srcA;

  ////////////////////
  // Operation select
  ////////////////////
  always_comb begin
    case (amoOp)
      atomicPkg::amoSwap: begin
        result = srcB;           // Plain exchange
      end
      atomicPkg::amoAdd: begin
        result = sum;
      end
      atomicPkg::amoXor: begin
        result = srcA ^ srcB;
      end
      atomicPkg::amoAnd: begin
        result = srcA & srcB;
      end
      atomicPkg::amoOr: begin
        result = srcA | srcB;
      end
      atomicPkg::amoMin: begin
        result = minS;
      end
      atomicPkg::amoMax: begin
        result = maxS;
      end
      atomicPkg::amoMinu: begin
        result = minU;
      end
      atomicPkg::amoMaxu: begin
        result = maxU;
      end
      default: begin
        // Unknown op rewrites the old word, memory keeps its value
        result = srcA;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hdl/lrscReservation.sv */
////////////////////
// LR/SC reservation tracker
// Holds one word reservation, squashes the write
// of a failing store-conditional and registers
// the failure for writeback
////////////////////

`timescale 1ns/1ps
`default_nettype none

module lrscReservation (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         stallW,         // Hold reservation and flag
  input  logic                         memRead,        // Read not ignored
  input  logic [1:0]                   preRw,          // Requested read/write code
  input  logic [1:0]                   atomicOp,       // 01 for LR/SC
  input  logic [atomicPkg::paBits-1:0] adr,            // Byte address
  input  logic                         ignoreRequest,  // Flush or miss
  output logic [1:0]                   lsuRw,          // Gated read/write code
  output logic                         squashScW       // SC failed last cycle
);

  localparam int resBits = atomicPkg::paBits - 2;  // Word address width

  logic               lrReq;     // Load-reserved
  logic               scReq;     // Store-conditional not ignored
  logic               adrMatch;  // Reservation hit
  logic               scFail;
  logic               resValid;
  logic [resBits-1:0] resAdr;    // Reserved word address

  ////////////////////
  // Request decode
  ////////////////////
  assign lrReq = memRead && (atomicOp == atomicPkg::atomLrsc) &&
                 (preRw == atomicPkg::rwRead);
  assign scReq = !ignoreRequest && (atomicOp == atomicPkg::atomLrsc) &&
                 (preRw == atomicPkg::rwWrite);

  assign adrMatch = resValid && (resAdr == adr[atomicPkg::paBits-1:2]);
  assign scFail   = scReq && !adrMatch;

  // No memory access on ignore or failed SC
  assign lsuRw = (ignoreRequest || scFail) ? atomicPkg::rwNone : preRw;

  ////////////////////
  // Reservation state
  ////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      resValid <= 1'b0;
    end else if (!stallW) begin
      if (lrReq) resValid <= 1'b1;       // New reservation
      else if (scReq) resValid <= 1'b0;  // Any SC consumes it
    end
  end

  // LR loads the reserved word address
  always_ff @(posedge clk) begin
    if (!stallW && lrReq) resAdr <= adr[atomicPkg::paBits-1:2];
  end

  // Failure flag for the writeback stage
  always_ff @(posedge clk) begin
    if (!rstN) squashScW <= 1'b0;
    else if (!stallW) squashScW <= scFail;
  end

  ////////////////////
  // Checks
  ////////////////////
  // Flag rises only after an unstalled SC whose write was dropped
  squashNeedsSc: assert property (@(posedge clk) disable iff (!rstN)
    $rose(squashScW) |-> $past((atomicOp == atomicPkg::atomLrsc) &&
                               (preRw == atomicPkg::rwWrite) &&
                               (lsuRw == atomicPkg::rwNone) && !stallW))
    else $error("squashScW rose without a dropped SC");

  // AMO code on the bus only for an AMO request
  amoCodeOnlyForAmo: assert property (@(posedge clk) disable iff (!rstN)
    (lsuRw == atomicPkg::rwAmo) |-> (atomicOp == atomicPkg::atomAmo))
    else $error("lsuRw is rwAmo without atomAmo");

endmodule

`default_nettype wire

/* hdl/atomicUnit.sv */
////////////////////
// Atomic unit
// Joins the AMO datapath and the LR/SC tracker,
// picks the memory write data and gates the
// read/write code
////////////////////

`timescale 1ns/1ps
`default_nettype none

module atomicUnit (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         stallW,
  input  logic [atomicPkg::xlen-1:0]   readData,       // Old word from memory
  input  logic [atomicPkg::xlen-1:0]   writeData,      // Store or AMO operand
  input  logic [atomicPkg::paBits-1:0] adr,            // Byte address
  input  logic [6:0]                   funct7,         // AMO op in bits 6:2
  input  logic [1:0]                   atomicOp,       // 10 AMO, 01 LR/SC
  input  logic [1:0]                   preRw,          // Requested read/write code
  input  logic                         ignoreRequest,  // Drop this request
  output logic [atomicPkg::xlen-1:0]   memWriteData,   // Store data or AMO result
  output logic                         squashScW,      // SC failed
  output logic [1:0]                   lsuRw           // Gated read/write code
);

  logic [atomicPkg::xlen-1:0] amoResult;
  logic                       memRead;

  ////////////////////
  // AMO datapath
  ////////////////////
  amoAlu alu (
    .srcA   (readData),
    .srcB   (writeData),
    .funct  (funct7),
    .result (amoResult)
  );

  // Atomic bit 1 selects the read-modify-write result
  assign memWriteData = atomicOp[1] ? amoResult : writeData;

  assign memRead = preRw[1] & ~ignoreRequest;  // Live read, LR included

  ////////////////////
  // LR/SC tracking
  ////////////////////
  lrscReservation lrsc (
    .clk,
    .rstN,
    .stallW,
    .memRead,
    .preRw,
    .atomicOp,
    .adr,
    .ignoreRequest,
    .lsuRw,
    .squashScW
  );

  // Both atomic bits set is not a legal request
  atomicCodeLegal: assert property (@(posedge clk) disable iff (!rstN)
    atomicOp != 2'b11)
    else $error("atomicOp is 11");

endmodule

`default_nettype wire

/* hdl/dataMemory.sv */
////////////////////
// Data memory
// Word-addressed RAM behind the atomic unit,
// combinational read and clocked write
////////////////////

`timescale 1ns/1ps
`default_nettype none

module dataMemory (
  input  logic                         clk,
  input  logic [1:0]                   lsuRw,      // Bit 0 writes
  input  logic [atomicPkg::paBits-1:0] adr,        // Byte address, word aligned
  input  logic [atomicPkg::xlen-1:0]   writeData,  // Word to store
  output logic [atomicPkg::xlen-1:0]   readData    // Current word at adr
);

  localparam int idxBits = atomicPkg::paBits - 2;

  logic [atomicPkg::xlen-1:0] mem [atomicPkg::memWords];
  logic [idxBits-1:0]         wordIdx;  // adr[7:2]

  assign wordIdx = adr[atomicPkg::paBits-1:2];

  ////////////////////
  // Contents
  ////////////////////
  // Starts cleared
  initial begin
    for (int i = 0; i < atomicPkg::memWords; i++) begin
      mem[i] = '0;
    end
  end

  // Old word visible in the request cycle
  assign readData = mem[wordIdx];

  // Store, SC or AMO lands on the edge
  always_ff @(posedge clk) begin
    if (lsuRw[0]) begin
      mem[wordIdx] <= writeData;
    end
  end

  ////////////////////
  // Checks
  ////////////////////
  // Only full words reach the memory
  alignedAccess: assert property (@(posedge clk)
    (lsuRw != atomicPkg::rwNone) |-> (adr[1:0] == 2'b00))
    else $error("misaligned access at %h", adr);

endmodule

`default_nettype wire

/* hdl/lsuAtomicTop.sv */
////////////////////
// LSU atomic top
// Atomic unit in front of a small data memory,
// so AMOs and SCs become real writes
////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsuAtomicTop (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic [1:0]                   preRw,          // 10 read, 01 write, 11 AMO
  input  logic [1:0]                   atomicOp,       // 10 AMO, 01 LR/SC
  input  logic [6:0]                   funct7,
  input  logic [atomicPkg::paBits-1:0] adr,
  input  logic [atomicPkg::xlen-1:0]   writeData,
  input  logic                         ignoreRequest,
  input  logic                         stallW,
  output logic [atomicPkg::xlen-1:0]   readData,       // Old word, same cycle
  output logic                         squashScW       // Registered SC failure
);

  logic [1:0]                 lsuRw;         // Gated code to memory
  logic [atomicPkg::xlen-1:0] memWriteData;  // Store data or AMO result

  ////////////////////
  // Atomic front end
  ////////////////////
  atomicUnit atomic (
    .clk,
    .rstN,
    .stallW,
    .readData,
    .writeData,
    .adr,
    .funct7,
    .atomicOp,
    .preRw,
    .ignoreRequest,
    .memWriteData,
    .squashScW,
    .lsuRw
  );

  // Backing store
  dataMemory mem (
    .clk,
    .lsuRw,
    .adr,
    .writeData (memWriteData),
    .readData
  );

endmodule

`default_nettype wire

/* testbench/atomicChecker.sv */
////////////////////
// Atomic checker
// Reference model of the word memory and the
// LR/SC reservation, compared with the DUT
// on every rising edge
////////////////////

`timescale 1ns/1ps
`default_nettype none

module atomicChecker (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic [1:0]                   preRw,
  input  logic [1:0]                   atomicOp,
  input  logic [6:0]                   funct7,
  input  logic [atomicPkg::paBits-1:0] adr,
  input  logic [atomicPkg::xlen-1:0]   writeData,
  input  logic                         ignoreRequest,
  input  logic                         stallW,
  input  logic [atomicPkg::xlen-1:0]   readData,     // DUT, same cycle
  input  logic                         squashScW,    // DUT, registered
  output int                           errorCount,
  output int                           checkCount,
  output int                           scPassCount,  // Successful SCs seen
  output int                           scFailCount
);

  logic [atomicPkg::xlen-1:0]   modelMem [atomicPkg::memWords];
  logic                         resValid;
  logic [atomicPkg::paBits-3:0] resIdx;     // Reserved word
  logic                         expSquash;  // Expected flag this cycle

  // New word of an AMO from old word and operand
  function automatic logic [atomicPkg::xlen-1:0] amoExpect(
      input logic [atomicPkg::xlen-1:0] oldWord,
      input logic [atomicPkg::xlen-1:0] operand,
      input logic [4:0]                 op);
    case (op)
      atomicPkg::amoSwap: return operand;
      atomicPkg::amoAdd:  return oldWord + operand;
      atomicPkg::amoXor:  return oldWord ^ operand;
      atomicPkg::amoAnd:  return oldWord & operand;
      atomicPkg::amoOr:   return oldWord | operand;
      atomicPkg::amoMin:  return ($signed(oldWord) < $signed(operand)) ? oldWord : operand;
      atomicPkg::amoMax:  return ($signed(oldWord) > $signed(operand)) ? oldWord : operand;
      atomicPkg::amoMinu: return (oldWord < operand) ? oldWord : operand;
      atomicPkg::amoMaxu: return (oldWord > operand) ? oldWord : operand;
      default:            return oldWord;  // Unknown op, no change
    endcase
  endfunction

  initial begin
    for (int i = 0; i < atomicPkg::memWords; i++) modelMem[i] = '0;
    resValid    = 1'b0;
    resIdx      = '0;
    expSquash   = 1'b0;
    errorCount  = 0;
    checkCount  = 0;
    scPassCount = 0;
    scFailCount = 0;
  end

  ////////////////////
  // Compare, then step the model
  ////////////////////
  always @(posedge clk) begin : compareStep
    logic [atomicPkg::paBits-3:0] idx;
    logic                         isLr;
    logic                         isSc;
    logic                         isAmo;
    logic                         scOk;
    idx = adr[atomicPkg::paBits-1:2];
    checkCount++;
    if (readData !== modelMem[idx]) begin  // Old word expected
      errorCount++;
      $display("Fail t=%0t readData got %h expected %h", $time, readData, modelMem[idx]);
    end
    if (rstN) begin  // Flag unknown until reset has acted
      checkCount++;
      if (squashScW !== expSquash) begin
        errorCount++;
        $display("Fail t=%0t squashScW got %b expected %b", $time, squashScW, expSquash);
      end
    end
    isLr  = !ignoreRequest && (atomicOp == atomicPkg::atomLrsc) && (preRw == atomicPkg::rwRead);
    isSc  = !ignoreRequest && (atomicOp == atomicPkg::atomLrsc) && (preRw == atomicPkg::rwWrite);
    isAmo = !ignoreRequest && (atomicOp == atomicPkg::atomAmo) && (preRw == atomicPkg::rwAmo);
    scOk  = isSc && resValid && (resIdx == idx);
    // Memory, stall does not block writes
    if (isAmo) modelMem[idx] = amoExpect(modelMem[idx], writeData, funct7[6:2]);
    else if (isSc) begin
      if (scOk) modelMem[idx] = writeData;
    end else if (!ignoreRequest && (preRw == atomicPkg::rwWrite)) modelMem[idx] = writeData;
    if (isSc && scOk) scPassCount++;
    if (isSc && !scOk) scFailCount++;
    // Reservation and flag
    if (!rstN) begin
      resValid  = 1'b0;
      expSquash = 1'b0;
    end else if (!stallW) begin
      expSquash = isSc && !scOk;
      if (isLr) begin
        resValid = 1'b1;
        resIdx   = idx;
      end else if (isSc) resValid = 1'b0;  // Any SC consumes it
    end
  end

endmodule

`default_nettype wire

/* testbench/atomicTb.sv */
////////////////////
// Atomic unit testbench
// Directed LR/SC prelude, then LFSR-driven
// AMO, LR, SC, load and store requests
////////////////////

`timescale 1ns/1ps
`default_nettype none

module atomicTb;

  localparam int numRequests   = 2000;
  localparam int timeoutCycles = numRequests + 100;  // Reset, prelude and drain fit in the margin

  logic                         clk;
  logic                         rstN;
  logic [1:0]                   preRw;
  logic [1:0]                   atomicOp;
  logic [6:0]                   funct7;
  logic [atomicPkg::paBits-1:0] adr;
  logic [atomicPkg::xlen-1:0]   writeData;
  logic                         ignoreRequest;
  logic                         stallW;
  logic [atomicPkg::xlen-1:0]   readData;
  logic                         squashScW;
  int                           errorCount;
  int                           checkCount;
  int                           scPassCount;
  int                           scFailCount;
  int                           scPassBase;  // SC counts once the prelude is done
  int                           scFailBase;
  int                           runErrors;   // Coverage gaps
  int                           cycleCount;
  logic [31:0]                  lfsr;

  lsuAtomicTop uut (
    .clk, .rstN, .preRw, .atomicOp, .funct7, .adr, .writeData,
    .ignoreRequest, .stallW, .readData, .squashScW
  );

  atomicChecker scoreboard (
    .clk, .rstN, .preRw, .atomicOp, .funct7, .adr, .writeData, .ignoreRequest,
    .stallW, .readData, .squashScW, .errorCount, .checkCount, .scPassCount, .scFailCount
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;  // 20 ns period

  ////////////////////
  // Random source
  ////////////////////
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic takeBits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr  = lfsrStep(lfsr);
      value = {value[30:0], lfsr[0]};  // One step per bit
    end
  endtask

  function automatic logic [4:0] amoCode(input int index);
    case (index)
      0: return atomicPkg::amoAdd;
      1: return atomicPkg::amoSwap;
      2: return atomicPkg::amoXor;
      3: return atomicPkg::amoOr;
      4: return atomicPkg::amoAnd;
      5: return atomicPkg::amoMin;
      6: return atomicPkg::amoMax;
      7: return atomicPkg::amoMinu;
      default: return atomicPkg::amoMaxu;
    endcase
  endfunction

  ////////////////////
  // Request drivers
  ////////////////////
  task automatic driveRequest(input logic [1:0] rw, input logic [1:0] atom, input logic [6:0] f7,
      input logic [2:0] word, input logic [31:0] data, input logic stall, input logic ignore);
    @(negedge clk);
    preRw         = rw;
    atomicOp      = atom;
    funct7        = f7;
    adr           = {3'b000, word, 2'b00};  // One of eight aligned words
    writeData     = data;
    stallW        = stall;
    ignoreRequest = ignore;
  endtask

  task automatic randomRequest();
    logic [31:0] kind;
    logic [31:0] word;
    logic [31:0] data;
    logic [31:0] opSel;
    logic [31:0] aqrl;
    logic [31:0] stallBits;
    logic [31:0] ignoreBits;
    logic [31:0] rawOp;
    logic [4:0]  op;
    logic        stall;
    logic        ignore;
    takeBits(3, kind);
    takeBits(3, word);
    takeBits(32, data);
    takeBits(4, opSel);
    takeBits(2, aqrl);
    takeBits(3, stallBits);
    takeBits(4, ignoreBits);
    stall  = (stallBits[2:0] == 3'd0);   // 1 in 8
    ignore = (ignoreBits[3:0] == 4'd0);  // 1 in 16
    if (opSel[3:0] == 4'd15) begin
      takeBits(5, rawOp);  // Any code including unknown ones
      op = rawOp[4:0];
    end else op = amoCode(opSel % 9);
    case (kind[2:0])
      3'd0, 3'd1: driveRequest(atomicPkg::rwAmo, atomicPkg::atomAmo, {op, aqrl[1:0]},
                               word[2:0], data, stall, ignore);
      3'd2, 3'd3: driveRequest(atomicPkg::rwRead, atomicPkg::atomLrsc, {5'd0, aqrl[1:0]},
                               word[2:0], data, stall, ignore);
      3'd4, 3'd5: driveRequest(atomicPkg::rwWrite, atomicPkg::atomLrsc, {5'd3, aqrl[1:0]},
                               word[2:0], data, stall, ignore);
      3'd6:       driveRequest(atomicPkg::rwRead, atomicPkg::atomNone, 7'd0,
                               word[2:0], data, stall, ignore);
      default:    driveRequest(atomicPkg::rwWrite, atomicPkg::atomNone, 7'd0,
                               word[2:0], data, stall, ignore);
    endcase
  endtask

  task automatic finishRun(input logic timedOut);
    $display("checks %0d, errors %0d, coverage errors %0d, SC pass %0d, SC fail %0d",
             checkCount, errorCount, runErrors, scPassCount, scFailCount);
    if (!timedOut && errorCount == 0 && runErrors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    lfsr          = 32'd30;
    runErrors     = 0;
    scPassBase    = 0;
    scFailBase    = 0;
    rstN          = 1'b0;
    preRw         = atomicPkg::rwNone;
    atomicOp      = atomicPkg::atomNone;
    funct7        = 7'd0;
    adr           = '0;
    writeData     = '0;
    ignoreRequest = 1'b0;
    stallW        = 1'b0;
    repeat (4) @(negedge clk);  // Four rising edges in reset
    rstN = 1'b1;
    driveRequest(atomicPkg::rwWrite, atomicPkg::atomLrsc, 7'd12, 3'd2, 32'h1111_0001, 0, 0);
    driveRequest(atomicPkg::rwRead, atomicPkg::atomLrsc, 7'd8, 3'd2, 32'h0, 0, 0);  // LR
    driveRequest(atomicPkg::rwWrite, atomicPkg::atomLrsc, 7'd12, 3'd2, 32'h2222_0002, 0, 0);
    driveRequest(atomicPkg::rwWrite, atomicPkg::atomLrsc, 7'd12, 3'd2, 32'h3333_0003, 0, 0);
    driveRequest(atomicPkg::rwNone, atomicPkg::atomNone, 7'd0, 3'd2, 32'h0, 0, 0);  // Idle
    scPassBase = scPassCount;  // Last prelude SC already sampled
    scFailBase = scFailCount;
    repeat (numRequests) randomRequest();
    driveRequest(atomicPkg::rwNone, atomicPkg::atomNone, 7'd0, 3'd2, 32'h0, 0, 0);  // Drain
    repeat (2) @(posedge clk);
    if (scPassCount == scPassBase) begin
      runErrors++;
      $display("No store-conditional succeeded during the random requests");
    end
    if (scFailCount == scFailBase) begin
      runErrors++;
      $display("No store-conditional failed during the random requests");
    end
    finishRun(1'b0);
  end

  // Watchdog
  initial begin
    cycleCount = 0;
    while (cycleCount < timeoutCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout after %0d cycles, stimulus did not finish", cycleCount);
    finishRun(1'b1);
  end

endmodule

`default_nettype wire

/* tb.f */
hdl/atomicPkg.sv
hdl/amoAlu.sv
hdl/lrscReservation.sv
hdl/atomicUnit.sv
hdl/dataMemory.sv
hdl/lsuAtomicTop.sv
testbench/atomicChecker.sv
testbench/atomicTb.sv
